/* Makefile */
# Verilator build and run for the wakeup CAM testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= wakeup_tb
RTL_TOP   ?= wakeup_top
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= STATUS: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* bench/wakeup_tb.sv */
// testbench for the wakeup CAM top level; shadow model plus assertions, run with list.f
`timescale 1ns/1ps

module wakeup_tb;
  import wakeup_pkg::*;

  localparam int CLK_PERIOD    = 20;
  localparam int RESET_CYCLES  = 8;
  localparam int RAND_CYCLES   = 150;
  localparam int MULTI_CYCLES  = 4;
  localparam int GATE_CYCLES   = 20;
  localparam int SWEEP_CYCLES  = 24;
  // three reconfigurations of two cycles each, plus reset and a margin
  localparam int TOTAL_CYCLES  = 2 + RESET_CYCLES + RAND_CYCLES + MULTI_CYCLES
                                 + 6 + 2 * GATE_CYCLES + SWEEP_CYCLES;
  localparam int WATCHDOG_CYCLES = TOTAL_CYCLES + 100;

  logic                         clk = 1'b0;
  logic                         rst_i;
  dispatch_mask_t               disp_we;
  iq_index_t [DISPATCH_WIDTH-1:0] disp_addr;
  tag_t [DISPATCH_WIDTH-1:0]    disp_tag;
  tag_t [ISSUE_WIDTH-1:0]       issue_tag;
  wake_vect_t [ISSUE_WIDTH-1:0] wake_vect;
  logic                         cfg_we;
  dispatch_mask_t               cfg_disp;
  issue_mask_t                  cfg_issue;
  part_mask_t                   cfg_part;
  logic                         cam_ready;

  string       test_name = "reset";
  logic [31:0] lfsr_q = 32'd77045;
  tag_t        prev_tag [DISPATCH_WIDTH];

  // shadow model of entries, masks and the sweep window
  tag_t           m_tag [IQ_DEPTH];
  wake_vect_t     m_valid;
  dispatch_mask_t m_disp;
  issue_mask_t    m_issue;
  part_mask_t     m_part;
  int             m_sweep_left;

  logic                         exp_ready;
  wake_vect_t [ISSUE_WIDTH-1:0] exp_vect;

  always #(CLK_PERIOD / 2) clk = ~clk;

  wakeup_top dut
  (
    .clk                   (clk),
    .rst_i                 (rst_i),
    .disp_we_i             (disp_we),
    .disp_addr_i           (disp_addr),
    .disp_tag_i            (disp_tag),
    .issue_tag_i           (issue_tag),
    .wake_vect_o           (wake_vect),
    .cfg_we_i              (cfg_we),
    .cfg_dispatch_active_i (cfg_disp),
    .cfg_issue_active_i    (cfg_issue),
    .cfg_part_active_i     (cfg_part),
    .cam_ready_o           (cam_ready)
  );

  // expected ready flag and vectors from the shadow state
  always_comb
  begin
    exp_ready = (m_sweep_left == 0);
    for (int i = 0; i < ISSUE_WIDTH; i++)
    begin
      for (int e = 0; e < IQ_DEPTH; e++)
      begin
        exp_vect[i][e] = m_issue[i] & m_part[e / PART_DEPTH] & m_valid[e]
                         & (m_tag[e] == issue_tag[i]);
      end
    end
  end

  always @(posedge clk)
  begin : model_update
    part_mask_t newly;
    newly = cfg_part & ~m_part;
    if (rst_i)
    begin
      m_valid       <= '0;
      m_disp        <= '1;
      m_issue       <= '1;
      m_part        <= '1;
      m_sweep_left  <= 0;
    end
    else
    begin
      // lane order, so lane 1 wins on the same entry
      for (int l = 0; l < DISPATCH_WIDTH; l++)
      begin
        if (disp_we[l] && exp_ready && m_disp[l] && m_part[disp_addr[l] / PART_DEPTH])
        begin
          m_tag[disp_addr[l]]   <= disp_tag[l];
          m_valid[disp_addr[l]] <= 1'b1;
        end
      end
      if (m_sweep_left > 0)
      begin
        m_sweep_left <= m_sweep_left - 1;
      end
      else if (cfg_we)
      begin
        m_disp        <= cfg_disp;
        m_issue       <= cfg_issue;
        m_part        <= cfg_part;
        if (|newly)
        begin
          m_sweep_left <= PART_DEPTH;
          // stale entries of a reactivated partition never match again
          for (int e = 0; e < IQ_DEPTH; e++)
          begin
            if (newly[e / PART_DEPTH])
            begin
              m_valid[e] <= 1'b0;
            end
          end
        end
      end
    end
  end

  a_ready_chk: assert property (@(posedge clk) disable iff (rst_i) cam_ready == exp_ready)
  else
  begin
    $display("MISMATCH test=%s signal=cam_ready_o expected=%0b actual=%0b",
             test_name, $sampled(exp_ready), $sampled(cam_ready));
    $display("STATUS: FAIL");
    $fatal(1, "ready flag differs from the model");
  end

  for (genvar i = 0; i < ISSUE_WIDTH; i++)
  begin : g_vect_chk
    a_vect_chk: assert property (@(posedge clk) disable iff (rst_i)
      wake_vect[i] == exp_vect[i])
    else
    begin
      $display("MISMATCH test=%s lane=%0d expected=%h actual=%h",
               test_name, i, $sampled(exp_vect[i]), $sampled(wake_vect[i]));
      $display("STATUS: FAIL");
      $fatal(1, "wakeup vector differs from the model");
    end
  end

  // galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++)
    begin
      v      = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
    return v;
  endfunction

  task automatic write_pair(input dispatch_mask_t we, input iq_index_t a0, input tag_t t0,
                            input iq_index_t a1, input tag_t t1);
    disp_we      <= we;
    disp_addr[0] <= a0;
    disp_tag[0]  <= t0;
    disp_addr[1] <= a1;
    disp_tag[1]  <= t1;
  endtask

  task automatic broadcast(input tag_t t0, input tag_t t1);
    issue_tag[0] <= t0;
    issue_tag[1] <= t1;
  endtask

  // narrow tag range so repeats and overwrites happen often
  task automatic random_write_cycle();
    dispatch_mask_t we;
    iq_index_t      a0;
    iq_index_t      a1;
    tag_t           t0;
    tag_t           t1;
    we = DISPATCH_WIDTH'(rand_bits(DISPATCH_WIDTH));
    a0 = IQ_INDEX'(rand_bits(IQ_INDEX));
    a1 = IQ_INDEX'(rand_bits(IQ_INDEX));
    if (rand_bits(3) == 0)
    begin
      a1 = a0;
    end
    t0 = {4'h4, 4'(rand_bits(4))};
    t1 = {4'h4, 4'(rand_bits(4))};
    write_pair(we, a0, t0, a1, t1);
    prev_tag[0] = t0;
    prev_tag[1] = t1;
  endtask

  task automatic broadcast_prev();
    broadcast(rand_bits(1) != 0 ? prev_tag[1] : prev_tag[0],
              rand_bits(1) != 0 ? prev_tag[1] : prev_tag[0]);
  endtask

  task automatic configure(input dispatch_mask_t d, input issue_mask_t i, input part_mask_t p);
    @(posedge clk);
    disp_we   <= '0;
    cfg_we    <= 1'b1;
    cfg_disp  <= d;
    cfg_issue <= i;
    cfg_part  <= p;
    @(posedge clk);
    cfg_we    <= 1'b0;
  endtask

  initial
  begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired before the tests finished");
    $display("STATUS: FAIL");
    $fatal(1, "timeout");
  end

  initial
  begin : stimulus
    int low_cycles;
    rst_i       = 1'b1;
    disp_we     = '0;
    disp_addr   = '0;
    disp_tag    = '0;
    issue_tag   = '0;
    cfg_we      = 1'b0;
    cfg_disp    = '1;
    cfg_issue   = '1;
    cfg_part    = '1;
    prev_tag[0] = '0;
    prev_tag[1] = '0;
    repeat (2) @(posedge clk);
    rst_i <= 1'b0;

    test_name = "reset_state";
    repeat (RESET_CYCLES)
    begin
      @(posedge clk);
      broadcast(8'(rand_bits(8)), 8'(rand_bits(8)));
    end

    test_name = "random_writes";
    repeat (RAND_CYCLES)
    begin
      @(posedge clk);
      broadcast_prev();
      random_write_cycle();
    end

    test_name = "multi_match";
    @(posedge clk);
    write_pair(2'b11, 4'd1, 8'h5a, 4'd6, 8'h5a);
    @(posedge clk);
    write_pair(2'b11, 4'd11, 8'h5a, 4'd14, 8'h5a);
    @(posedge clk);
    disp_we <= '0;
    broadcast(8'h5a, 8'h5a);
    @(posedge clk);
    broadcast(8'h00, 8'h5a);

    test_name = "lane_gating";
    configure(2'b01, 2'b10, 4'b1111);
    repeat (GATE_CYCLES)
    begin
      @(posedge clk);
      broadcast_prev();
      random_write_cycle();
    end
    configure(2'b10, 2'b01, 4'b1111);
    repeat (GATE_CYCLES)
    begin
      @(posedge clk);
      broadcast_prev();
      random_write_cycle();
    end
    configure('1, '1, '1);

    test_name = "part_sweep";
    @(posedge clk);
    write_pair(2'b11, 4'd8, 8'h33, 4'd9, 8'h33);
    @(posedge clk);
    write_pair(2'b11, 4'd10, 8'h33, 4'd11, 8'h33);
    @(posedge clk);
    disp_we <= '0;
    broadcast(8'h33, 8'h33);
    configure('1, '1, 4'b1011);
    // partition 2 is off, so entry 9 drops and entry 2 lands
    @(posedge clk);
    write_pair(2'b11, 4'd9, 8'h44, 4'd2, 8'h44);
    @(posedge clk);
    disp_we <= '0;
    broadcast(8'h33, 8'h44);
    @(posedge clk);
    cfg_we   <= 1'b1;
    cfg_part <= 4'b1111;
    @(posedge clk);
    // an update inside the sweep window has to be ignored
    cfg_part <= 4'b0001;
    random_write_cycle();
    low_cycles = 0;
    forever
    begin
      @(negedge clk);
      if (cam_ready)
      begin
        break;
      end
      low_cycles++;
      @(posedge clk);
      cfg_we <= 1'b0;
      // lane 1 looks for a write that should have been dropped
      broadcast(8'h33, rand_bits(1) != 0 ? prev_tag[1] : prev_tag[0]);
      random_write_cycle();
    end
    a_sweep_len: assert (low_cycles == PART_DEPTH)
    else
    begin
      $display("MISMATCH test=%s signal=sweep_length expected=%0d actual=%0d",
               test_name, PART_DEPTH, low_cycles);
      $display("STATUS: FAIL");
      $fatal(1, "sweep window has the wrong length");
    end
    @(posedge clk);
    cfg_we   <= 1'b0;
    cfg_part <= 4'b1111;
    disp_we  <= '0;
    broadcast(8'h33, 8'h44);
    @(posedge clk);
    write_pair(2'b01, 4'd10, 8'h77, 4'd0, 8'h00);
    @(posedge clk);
    disp_we <= '0;
    broadcast(8'h77, 8'h33);
    repeat (2) @(posedge clk);

    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* design/iq_power_ctrl.sv */
// lane and partition activity registers with a clearing sweep on partition reactivation
`timescale 1ns/1ps

module iq_power_ctrl
(
  input  logic                       clk,
  input  logic                       rst_i,
  input  logic                       cfg_we_i,
  input  wakeup_pkg::dispatch_mask_t cfg_dispatch_i,
  input  wakeup_pkg::issue_mask_t    cfg_issue_i,
  input  wakeup_pkg::part_mask_t     cfg_part_i,
  cam_gate_if.ctrl                   gate,
  output logic                       ready_o
);
  import wakeup_pkg::*;

  ctrl_state_t    state_q;
  part_index_t    cnt_q;
  dispatch_mask_t disp_q;
  issue_mask_t    issue_q;
  part_mask_t     part_q;
  part_mask_t     sweep_mask_q;

  logic           accept;
  part_mask_t     reactivate;
  logic           sweeping;

  assign accept     = cfg_we_i & (state_q == CTRL_READY);
  // partitions going from off to on
  assign reactivate = cfg_part_i & ~part_q;
  assign sweeping   = (state_q == CTRL_SWEEP);

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      state_q      <= CTRL_READY;
      cnt_q        <= '0;
      disp_q       <= '1;
      issue_q      <= '1;
      part_q       <= '1;
      sweep_mask_q <= '0;
    end
    else
    begin
      case (state_q)
        CTRL_READY:
        begin
          if (accept)
          begin
            disp_q       <= cfg_dispatch_i;
            issue_q      <= cfg_issue_i;
            part_q       <= cfg_part_i;
            sweep_mask_q <= reactivate;
            cnt_q        <= '0;
            if (|reactivate)
            begin
              state_q <= CTRL_SWEEP;
            end
          end
        end
        CTRL_SWEEP:
        begin
          // one entry per cycle, counter wraps back to zero at the end
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == PART_INDEX'(PART_DEPTH - 1))
          begin
            state_q <= CTRL_READY;
          end
        end
        default:
        begin
          state_q <= CTRL_READY;
        end
      endcase
    end
  end

  assign ready_o = ~sweeping;

  // no dispatch while sweeping
  assign gate.dispatch_active = sweeping ? '0 : disp_q;
  assign gate.issue_active    = issue_q;
  // swept banks stay dark until every stale entry is gone
  assign gate.part_active     = sweeping ? (part_q & ~sweep_mask_q) : part_q;
  assign gate.sweep_mask      = sweep_mask_q;
  assign gate.sweep_en        = sweeping;
  assign gate.sweep_addr      = cnt_q;

  // a reactivating update holds ready low for exactly one full bank sweep
  a_sweep_len: assert property (@(posedge clk) disable iff (rst_i)
    (accept && |reactivate) |=> !ready_o [*PART_DEPTH] ##1 ready_o);

endmodule

/* design/wakeup_cam_bank.sv */
// one partition of the wakeup CAM; stores tags per entry and matches every issue broadcast
`timescale 1ns/1ps

module wakeup_cam_bank
(
  input  logic                                                 clk,
  input  logic                                                 rst_i,
  bank_wr_if.bank                                              wr,
  input  logic                                                 part_on_i,
  input  wakeup_pkg::tag_t [wakeup_pkg::ISSUE_WIDTH-1:0]       tag_i,
  output wakeup_pkg::part_vect_t [wakeup_pkg::ISSUE_WIDTH-1:0] vect_o
);
  import wakeup_pkg::*;

  tag_t       tag_q [PART_DEPTH];
  part_vect_t valid_q;

  // tag storage, later lanes overwrite earlier ones on the same entry
  always_ff @(posedge clk)
  begin
    for (int wp = 0; wp < DISPATCH_WIDTH; wp++)
    begin
      if (wr.we[wp])
      begin
        tag_q[wr.addr[wp]] <= wr.data[wp];
      end
    end
  end

  // valid bits
  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      valid_q <= '0;
    end
    else
    begin
      for (int wp = 0; wp < DISPATCH_WIDTH; wp++)
      begin
        if (wr.we[wp])
        begin
          valid_q[wr.addr[wp]] <= 1'b1;
        end
      end
      // sweep clear wins over a write to the same entry
      if (wr.clr_en)
      begin
        valid_q[wr.clr_addr] <= 1'b0;
      end
    end
  end

  // match every broadcast tag against every valid entry
  always_comb
  begin
    for (int rp = 0; rp < ISSUE_WIDTH; rp++)
    begin
      for (int e = 0; e < PART_DEPTH; e++)
      begin
        vect_o[rp][e] = part_on_i & valid_q[e] & (tag_q[e] == tag_i[rp]);
      end
    end
  end

  // entry addresses stay inside the bank
  a_clr_range: assert property (@(posedge clk) disable iff (rst_i)
    wr.clr_en |-> (int'(wr.clr_addr) < PART_DEPTH));

  for (genvar wp = 0; wp < DISPATCH_WIDTH; wp++)
  begin : g_wr_chk
    a_wr_range: assert property (@(posedge clk) disable iff (rst_i)
      wr.we[wp] |-> (int'(wr.addr[wp]) < PART_DEPTH));
  end

  // the routing upstream must never write a bank that is switched off
  a_wr_when_on: assert property (@(posedge clk) disable iff (rst_i)
    (|wr.we) |-> part_on_i);

endmodule

/* design/wakeup_cam_partitioned.sv */
// full wakeup CAM; routes writes to partition banks, applies gating and builds wakeup vectors
`timescale 1ns/1ps

module wakeup_cam_partitioned
(
  input  logic                                                    clk,
  input  logic                                                    rst_i,
  cam_gate_if.cam                                                 gate,
  input  wakeup_pkg::dispatch_mask_t                              we_i,
  input  wakeup_pkg::iq_index_t [wakeup_pkg::DISPATCH_WIDTH-1:0]  addr_i,
  input  wakeup_pkg::tag_t [wakeup_pkg::DISPATCH_WIDTH-1:0]       data_i,
  input  wakeup_pkg::tag_t [wakeup_pkg::ISSUE_WIDTH-1:0]          tag_i,
  output wakeup_pkg::wake_vect_t [wakeup_pkg::ISSUE_WIDTH-1:0]    vect_o
);
  import wakeup_pkg::*;

  // address split, top bits pick the bank
  logic [DISPATCH_WIDTH-1:0][PART_LOG-1:0]  part_sel;
  part_index_t [DISPATCH_WIDTH-1:0]         bank_addr;

  // lane_sel[l][p] is lane l writing bank p this cycle
  logic [DISPATCH_WIDTH-1:0][NUM_PARTS-1:0] lane_sel;

  part_vect_t [ISSUE_WIDTH-1:0]             bank_vect [NUM_PARTS];

  for (genvar l = 0; l < DISPATCH_WIDTH; l++)
  begin : g_lane
    assign part_sel[l]  = addr_i[l][IQ_INDEX-1 -: PART_LOG];
    assign bank_addr[l] = addr_i[l][PART_INDEX-1:0];

    for (genvar p = 0; p < NUM_PARTS; p++)
    begin : g_route
      assign lane_sel[l][p] = we_i[l] & gate.dispatch_active[l] & gate.part_active[p]
                              & (part_sel[l] == PART_LOG'(p));
    end

    a_one_bank: assert property (@(posedge clk) disable iff (rst_i)
      $onehot0(lane_sel[l]));
  end

  for (genvar p = 0; p < NUM_PARTS; p++)
  begin : g_part
    bank_wr_if wr_bus ();

    always_comb
    begin
      for (int l = 0; l < DISPATCH_WIDTH; l++)
      begin
        wr_bus.we[l] = lane_sel[l][p];
      end
    end

    assign wr_bus.addr     = bank_addr;
    assign wr_bus.data     = data_i;
    // only banks in the sweep mask see the clear strobe
    assign wr_bus.clr_en   = gate.sweep_en & gate.sweep_mask[p];
    assign wr_bus.clr_addr = gate.sweep_addr;

    wakeup_cam_bank u_bank
    (
      .clk       (clk),
      .rst_i     (rst_i),
      .wr        (wr_bus.bank),
      .part_on_i (gate.part_active[p]),
      .tag_i     (tag_i),
      .vect_o    (bank_vect[p])
    );
  end

  // bank p fills entries p*PART_DEPTH upward
  always_comb
  begin
    for (int rp = 0; rp < ISSUE_WIDTH; rp++)
    begin
      for (int p = 0; p < NUM_PARTS; p++)
      begin
        vect_o[rp][p*PART_DEPTH +: PART_DEPTH] =
          gate.issue_active[rp] ? bank_vect[p][rp] : '0;
      end
    end
  end

endmodule

/* design/wakeup_ifs.sv */
// bank write bus and lane/partition gating bus shared between the CAM blocks
`timescale 1ns/1ps

interface bank_wr_if;
  import wakeup_pkg::*;

  // dispatch write ports, already routed to this bank
  dispatch_mask_t                       we;
  part_index_t [DISPATCH_WIDTH-1:0]     addr;
  tag_t [DISPATCH_WIDTH-1:0]            data;

  // sweep clear of one entry
  logic                                 clr_en;
  part_index_t                          clr_addr;

  modport src
  (
    output we, addr, data, clr_en, clr_addr
  );

  modport bank
  (
    input we, addr, data, clr_en, clr_addr
  );

endinterface

interface cam_gate_if;
  import wakeup_pkg::*;

  dispatch_mask_t dispatch_active;
  issue_mask_t    issue_active;
  part_mask_t     part_active;

  // banks being swept and the entry cleared this cycle
  part_mask_t     sweep_mask;
  logic           sweep_en;
  part_index_t    sweep_addr;

  modport ctrl
  (
    output dispatch_active, issue_active, part_active, sweep_mask, sweep_en, sweep_addr
  );

  modport cam
  (
    input dispatch_active, issue_active, part_active, sweep_mask, sweep_en, sweep_addr
  );

endinterface

/* design/wakeup_pkg.sv */
// shared sizes, vector types and controller states for the wakeup CAM; import where needed
package wakeup_pkg;

  // lane counts
  localparam int DISPATCH_WIDTH = 2;
  localparam int ISSUE_WIDTH    = 2;

  // queue geometry
  localparam int IQ_DEPTH   = 16;
  localparam int IQ_INDEX   = 4;
  localparam int NUM_PARTS  = 4;
  localparam int PART_LOG   = 2;
  localparam int PART_DEPTH = IQ_DEPTH / NUM_PARTS;
  localparam int PART_INDEX = IQ_INDEX - PART_LOG;

  // physical register tag
  localparam int TAG_WIDTH = 8;

  typedef logic [TAG_WIDTH-1:0]      tag_t;
  typedef logic [IQ_INDEX-1:0]       iq_index_t;
  typedef logic [PART_INDEX-1:0]     part_index_t;

  // one bit per queue entry, or per bank entry
  typedef logic [IQ_DEPTH-1:0]       wake_vect_t;
  typedef logic [PART_DEPTH-1:0]     part_vect_t;

  // activity masks, one bit per lane or partition
  typedef logic [DISPATCH_WIDTH-1:0] dispatch_mask_t;
  typedef logic [ISSUE_WIDTH-1:0]    issue_mask_t;
  typedef logic [NUM_PARTS-1:0]      part_mask_t;

  // ready while idle, sweep while clearing reactivated banks
  typedef enum logic
  {
    CTRL_READY = 1'b0,
    CTRL_SWEEP = 1'b1
  } ctrl_state_t;

endpackage

/* design/wakeup_top.sv */
// top level of the partitioned wakeup CAM with its activity controller, plain ports only
`timescale 1ns/1ps

module wakeup_top
(
  input  logic                                                             clk,
  input  logic                                                             rst_i,

  // dispatch writes
  input  logic [wakeup_pkg::DISPATCH_WIDTH-1:0]                            disp_we_i,
  input  logic [wakeup_pkg::DISPATCH_WIDTH-1:0][wakeup_pkg::IQ_INDEX-1:0]  disp_addr_i,
  input  logic [wakeup_pkg::DISPATCH_WIDTH-1:0][wakeup_pkg::TAG_WIDTH-1:0] disp_tag_i,

  // issue broadcasts and wakeup vectors
  input  logic [wakeup_pkg::ISSUE_WIDTH-1:0][wakeup_pkg::TAG_WIDTH-1:0]    issue_tag_i,
  output logic [wakeup_pkg::ISSUE_WIDTH-1:0][wakeup_pkg::IQ_DEPTH-1:0]     wake_vect_o,

  // configuration
  input  logic                                                             cfg_we_i,
  input  logic [wakeup_pkg::DISPATCH_WIDTH-1:0]                            cfg_dispatch_active_i,
  input  logic [wakeup_pkg::ISSUE_WIDTH-1:0]                               cfg_issue_active_i,
  input  logic [wakeup_pkg::NUM_PARTS-1:0]                                 cfg_part_active_i,
  output logic                                                             cam_ready_o
);

  cam_gate_if gate_bus ();

  // activity masks and sweep sequencing
  iq_power_ctrl u_ctrl
  (
    .clk            (clk),
    .rst_i          (rst_i),
    .cfg_we_i       (cfg_we_i),
    .cfg_dispatch_i (cfg_dispatch_active_i),
    .cfg_issue_i    (cfg_issue_active_i),
    .cfg_part_i     (cfg_part_active_i),
    .gate           (gate_bus.ctrl),
    .ready_o        (cam_ready_o)
  );

  // partition banks and vector assembly
  wakeup_cam_partitioned u_cam
  (
    .clk    (clk),
    .rst_i  (rst_i),
    .gate   (gate_bus.cam),
    .we_i   (disp_we_i),
    .addr_i (disp_addr_i),
    .data_i (disp_tag_i),
    .tag_i  (issue_tag_i),
    .vect_o (wake_vect_o)
  );

endmodule

/* list.f */
design/wakeup_pkg.sv
design/wakeup_ifs.sv
design/wakeup_cam_bank.sv
design/wakeup_cam_partitioned.sv
design/iq_power_ctrl.sv
design/wakeup_top.sv
bench/wakeup_tb.sv
